/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int NUM_REGS   = 32;
	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = $clog2(NUM_REGS);
	localparam int IM_ADDR_W  = 10;
	localparam int DM_ADDR_W  = 12;
	localparam int OPCODE_W   = 6;
	localparam int SUB_OP_W   = 5;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [IM_ADDR_W-1:0]  im_addr_t;
	typedef logic [DM_ADDR_W-1:0]  dm_addr_t;
	typedef logic [OPCODE_W-1:0]   opcode_t;
	typedef logic [SUB_OP_W-1:0]   sub_op_t;

	// opcodes, anything else decodes as a nop
	localparam opcode_t OP_ALU  = 6'd0;
	localparam opcode_t OP_LWI  = 6'd2;
	localparam opcode_t OP_SWI  = 6'd3;
	localparam opcode_t OP_BEQ  = 6'd4;
	localparam opcode_t OP_ADDI = 6'd8;
	localparam opcode_t OP_NOP  = 6'd63;

	localparam sub_op_t SUB_ADD = 5'd0;
	localparam sub_op_t SUB_SUB = 5'd1;
	localparam sub_op_t SUB_AND = 5'd2;
	localparam sub_op_t SUB_OR  = 5'd3;
	localparam sub_op_t SUB_XOR = 5'd4;

	// fill value for an empty IF/ID register
	localparam word_t NOP_WORD = {OP_NOP, 26'd0};

	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    use_imm;
		sub_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     ra_data;
		word_t     rt_data;
		word_t     imm;
		reg_addr_t dest;
	} id_ex_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     alu_result;
		word_t     store_data;
		reg_addr_t dest;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		reg_addr_t dest;
		word_t     wb_data;
	} mem_wb_t;

endpackage

`default_nettype wire

/* source/fetch_pc.sv */
`default_nettype none

module fetch_pc (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              stall,
	input  logic              branch_taken,
	input  cpu_pkg::im_addr_t branch_target,
	output cpu_pkg::im_addr_t pc,
	output logic              fetch_active
);

	// stall wins, a taken branch is already gated by it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (stall) begin
			pc <= pc;
		end else if (branch_taken) begin
			pc <= branch_target;
		end else begin
			pc <= pc + 1'b1;
		end
	end

	// fetch starts on the first clock out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_active <= 1'b0;
		end else begin
			fetch_active <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/decoder.sv */
`default_nettype none

module decoder (
	input  cpu_pkg::word_t     instruction,
	output cpu_pkg::ctrl_t     ctrl,
	output cpu_pkg::reg_addr_t ra_addr,
	output cpu_pkg::reg_addr_t rt_addr,
	output cpu_pkg::reg_addr_t rb_addr,
	output cpu_pkg::word_t     imm,
	output logic               is_branch
);

	import cpu_pkg::*;

	opcode_t opcode;
	sub_op_t sub_op;

	assign opcode  = instruction[31:26];
	assign sub_op  = instruction[4:0];
	assign rt_addr = instruction[25:21];
	assign ra_addr = instruction[20:16];
	assign imm     = {{16{instruction[15]}}, instruction[15:0]};

	// second read port: rb for reg-reg ops, rt for store and beq
	assign rb_addr = (opcode == OP_ALU) ? instruction[15:11] : instruction[25:21];

	always_comb begin
		ctrl      = '0;
		is_branch = 1'b0;
		case (opcode)
			OP_ALU: begin
				// unknown sub-op stays a nop
				if (sub_op <= SUB_XOR) begin
					ctrl.reg_write = 1'b1;
					ctrl.alu_op    = sub_op;
				end
			end
			OP_ADDI: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm   = 1'b1;
				ctrl.alu_op    = SUB_ADD;
			end
			OP_LWI: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.use_imm   = 1'b1;
				ctrl.alu_op    = SUB_ADD;
			end
			OP_SWI: begin
				ctrl.mem_write = 1'b1;
				ctrl.use_imm   = 1'b1;
				ctrl.alu_op    = SUB_ADD;
			end
			OP_BEQ: begin
				// resolved in decode, nothing goes down the pipe
				is_branch = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/regfile.sv */
`default_nettype none

module regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::reg_addr_t ra_addr,
	input  cpu_pkg::reg_addr_t rb_addr,
	input  cpu_pkg::mem_wb_t   wb,
	output cpu_pkg::word_t     ra_data,
	output cpu_pkg::word_t     rb_data
);

	import cpu_pkg::*;

	word_t regs [NUM_REGS];

	// same-cycle write is covered by wb forwarding
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.reg_write) begin
			regs[wb.dest] <= wb.wb_data;
		end
	end

endmodule

`default_nettype wire

/* source/operand_forward.sv */
`default_nettype none

module operand_forward (
	input  cpu_pkg::reg_addr_t ra_addr,
	input  cpu_pkg::reg_addr_t src2_addr,
	input  cpu_pkg::word_t     ra_raw,
	input  cpu_pkg::word_t     src2_raw,
	input  cpu_pkg::ex_mem_t   ex,
	input  cpu_pkg::id_ex_t    ex_ctrl_dest,
	input  cpu_pkg::ex_mem_t   mem,
	input  cpu_pkg::word_t     mem_load_data,
	input  cpu_pkg::mem_wb_t   wb,
	input  logic               is_branch,
	output cpu_pkg::word_t     ra_fwd,
	output cpu_pkg::word_t     src2_fwd,
	output logic               stall,
	output logic               branch_taken
);

	import cpu_pkg::*;

	logic  ex_can_fwd;
	word_t mem_value;

	// a load in execute has no data yet
	assign ex_can_fwd = ex.ctrl.reg_write && !ex.ctrl.mem_read;
	assign mem_value  = mem.ctrl.mem_read ? mem_load_data : mem.alu_result;

	function automatic word_t pick(input reg_addr_t addr, input word_t raw);
		word_t v;
		if (ex_can_fwd && ex.dest == addr) begin
			v = ex.alu_result;
		end else if (mem.ctrl.reg_write && mem.dest == addr) begin
			v = mem_value;
		end else if (wb.reg_write && wb.dest == addr) begin
			v = wb.wb_data;
		end else begin
			v = raw;
		end
		return v;
	endfunction

	always_comb begin
		ra_fwd   = pick(ra_addr, ra_raw);
		src2_fwd = pick(src2_addr, src2_raw);
	end

	// load-use, one bubble
	assign stall = ex_ctrl_dest.ctrl.mem_read &&
		(ex_ctrl_dest.dest == ra_addr || ex_ctrl_dest.dest == src2_addr);

	assign branch_taken = is_branch && !stall && (ra_fwd == src2_fwd);

endmodule

`default_nettype wire

/* source/alu.sv */
`default_nettype none

module alu (
	input  cpu_pkg::id_ex_t stage,
	output cpu_pkg::word_t  result,
	output logic            overflow
);

	import cpu_pkg::*;

	word_t src1;
	word_t src2;
	logic  valid;
	logic  add_ovf;
	logic  sub_ovf;

	assign src1  = stage.ra_data;
	assign src2  = stage.ctrl.use_imm ? stage.imm : stage.rt_data;
	// bubbles carry all-zero control, which also reads as add
	assign valid = stage.ctrl.reg_write | stage.ctrl.mem_read | stage.ctrl.mem_write;

	always_comb begin
		case (stage.ctrl.alu_op)
			SUB_ADD: result = src1 + src2;
			SUB_SUB: result = src1 - src2;
			SUB_AND: result = src1 & src2;
			SUB_OR:  result = src1 | src2;
			SUB_XOR: result = src1 ^ src2;
			default: result = '0;
		endcase
	end

	// sign of result differs from what the operand signs allow
	assign add_ovf = (src1[31] == src2[31]) && (result[31] != src1[31]);
	assign sub_ovf = (src1[31] != src2[31]) && (result[31] != src1[31]);

	assign overflow = valid &&
		((stage.ctrl.alu_op == SUB_ADD && add_ovf) || (stage.ctrl.alu_op == SUB_SUB && sub_ovf));

endmodule

`default_nettype wire

/* source/stage_regs.sv */
`default_nettype none

module stage_regs (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              stall,
	input  logic              flush,
	input  cpu_pkg::word_t    if_instruction,
	input  cpu_pkg::im_addr_t if_pc,
	input  cpu_pkg::id_ex_t   id_in,
	input  cpu_pkg::word_t    ex_result,
	input  cpu_pkg::word_t    dm_out,
	output cpu_pkg::word_t    id_instruction,
	output cpu_pkg::im_addr_t id_pc,
	output cpu_pkg::id_ex_t   ex_stage,
	output cpu_pkg::ex_mem_t  mem_stage,
	output cpu_pkg::mem_wb_t  wb_stage
);

	import cpu_pkg::*;

	// IF/ID
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_instruction <= NOP_WORD;
			id_pc          <= '0;
		end else if (stall) begin
			id_instruction <= id_instruction;
			id_pc          <= id_pc;
		end else if (flush) begin
			id_instruction <= NOP_WORD;
			id_pc          <= '0;
		end else begin
			id_instruction <= if_instruction;
			id_pc          <= if_pc;
		end
	end

	// ID/EX, bubble while decode waits on a load
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_stage <= '0;
		end else begin
			ex_stage <= stall ? '0 : id_in;
		end
	end

	// EX/MEM
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_stage <= '0;
		end else begin
			mem_stage.ctrl       <= ex_stage.ctrl;
			mem_stage.alu_result <= ex_result;
			mem_stage.store_data <= ex_stage.rt_data;
			mem_stage.dest       <= ex_stage.dest;
		end
	end

	// MEM/WB, load data or alu result
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_stage <= '0;
		end else begin
			wb_stage.reg_write <= mem_stage.ctrl.reg_write;
			wb_stage.dest      <= mem_stage.dest;
			wb_stage.wb_data   <= mem_stage.ctrl.mem_read ? dm_out : mem_stage.alu_result;
		end
	end

endmodule

`default_nettype wire

/* source/pipeline_top.sv */
`default_nettype none

module pipeline_top (
	input  logic              clk,
	input  logic              rst_n,
	input  cpu_pkg::word_t    instruction,
	output logic              im_read,
	output cpu_pkg::im_addr_t im_address,
	output logic              dm_read,
	output logic              dm_write,
	output cpu_pkg::dm_addr_t dm_address,
	output cpu_pkg::word_t    dm_in,
	input  cpu_pkg::word_t    dm_out,
	output logic              alu_overflow
);

	import cpu_pkg::*;

	logic      stall;
	logic      branch_taken;
	logic      is_branch;
	im_addr_t  branch_target;
	im_addr_t  id_pc;
	word_t     id_instruction;
	ctrl_t     id_ctrl;
	reg_addr_t ra_addr;
	reg_addr_t rt_addr;
	reg_addr_t src2_addr;
	word_t     imm;
	word_t     ra_raw;
	word_t     src2_raw;
	word_t     ra_fwd;
	word_t     src2_fwd;
	word_t     alu_result;
	id_ex_t    id_out;
	id_ex_t    ex_stage;
	ex_mem_t   ex_view;
	ex_mem_t   mem_stage;
	mem_wb_t   wb_stage;

	assign branch_target = id_pc + im_addr_t'(imm);

	assign id_out  = '{ctrl: id_ctrl, ra_data: ra_fwd, rt_data: src2_fwd, imm: imm, dest: rt_addr};
	// execute result seen by decode before it is registered
	assign ex_view = '{ctrl: ex_stage.ctrl, alu_result: alu_result,
		store_data: ex_stage.rt_data, dest: ex_stage.dest};

	assign dm_read    = mem_stage.ctrl.mem_read;
	assign dm_write   = mem_stage.ctrl.mem_write;
	assign dm_address = dm_addr_t'(mem_stage.alu_result);
	assign dm_in      = mem_stage.store_data;

	fetch_pc fetch_pc_i (
		.clk(clk), .rst_n(rst_n),
		.stall(stall), .branch_taken(branch_taken), .branch_target(branch_target),
		.pc(im_address), .fetch_active(im_read)
	);

	decoder decoder_i (
		.instruction(id_instruction), .ctrl(id_ctrl),
		.ra_addr(ra_addr), .rt_addr(rt_addr), .rb_addr(src2_addr),
		.imm(imm), .is_branch(is_branch)
	);

	regfile regfile_i (
		.clk(clk), .rst_n(rst_n),
		.ra_addr(ra_addr), .rb_addr(src2_addr), .wb(wb_stage),
		.ra_data(ra_raw), .rb_data(src2_raw)
	);

	operand_forward operand_forward_i (
		.ra_addr(ra_addr), .src2_addr(src2_addr),
		.ra_raw(ra_raw), .src2_raw(src2_raw),
		.ex(ex_view), .ex_ctrl_dest(ex_stage),
		.mem(mem_stage), .mem_load_data(dm_out), .wb(wb_stage),
		.is_branch(is_branch),
		.ra_fwd(ra_fwd), .src2_fwd(src2_fwd),
		.stall(stall), .branch_taken(branch_taken)
	);

	alu alu_i (
		.stage(ex_stage), .result(alu_result), .overflow(alu_overflow)
	);

	stage_regs stage_regs_i (
		.clk(clk), .rst_n(rst_n),
		.stall(stall), .flush(branch_taken),
		.if_instruction(instruction), .if_pc(im_address),
		.id_in(id_out), .ex_result(alu_result), .dm_out(dm_out),
		.id_instruction(id_instruction), .id_pc(id_pc),
		.ex_stage(ex_stage), .mem_stage(mem_stage), .wb_stage(wb_stage)
	);

endmodule

`default_nettype wire

/* tb/pipeline_props.sv */
`default_nettype none

module pipeline_props (
	input logic             clk,
	input logic             rst_n,
	input logic             stall,
	input logic             flush,
	input cpu_pkg::id_ex_t  ex_stage,
	input cpu_pkg::ex_mem_t mem_stage,
	input cpu_pkg::mem_wb_t wb_stage
);

	timeunit 1ns;
	timeprecision 100ps;

	// memory stage drives at most one data strobe
	strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_stage.ctrl.mem_read && mem_stage.ctrl.mem_write))
		else $error("dm_read and dm_write high in the same cycle");

	// a load-use hazard costs exactly one bubble
	stall_once: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> !stall)
		else $error("load-use stall lasted more than one cycle");

	// IF/ID is flushed once per taken branch
	flush_once: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> !flush)
		else $error("taken branch flushed IF/ID on two cycles in a row");

	// bubbles in every stage while held in reset
	reset_clears_ctrl: assert property (@(posedge clk)
		!rst_n |-> (ex_stage.ctrl == '0 && mem_stage.ctrl == '0 && !wb_stage.reg_write))
		else $error("pipeline control bit high during reset");

endmodule

bind stage_regs pipeline_props pipeline_props_i (.*);

`default_nettype wire

/* tb/pipeline_tb.sv */
`default_nettype none

module pipeline_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import cpu_pkg::*;

	localparam int    NUM_TESTS    = 6;
	localparam int    PROG_LEN     = 16;
	localparam int    CLK_PERIOD   = 8;
	localparam int    RESET_CYCLES = 10;
	localparam int    WATCHDOG_NS  = NUM_TESTS * 60 * CLK_PERIOD;
	localparam word_t NOP_INSTR    = {OP_NOP, 26'd0};

	typedef struct packed {
		word_t [PROG_LEN-1:0] prog;
		dm_addr_t             preload_addr;
		word_t                preload_data;
		logic [1:0]           skip_stores;
		dm_addr_t             exp_addr;
		word_t                exp_data;
		logic                 exp_ovf;
	} test_t;

	logic     clk;
	logic     rst_n;
	word_t    instruction;
	logic     im_read;
	im_addr_t im_address;
	logic     dm_read;
	logic     dm_write;
	dm_addr_t dm_address;
	word_t    dm_in;
	word_t    dm_out;
	logic     alu_overflow;

	word_t im_mem [1 << IM_ADDR_W];
	word_t dm_mem [1 << DM_ADDR_W];
	test_t tests [NUM_TESTS];
	int    checks;
	int    errors;

	pipeline_top pipeline_top_i (.*);

	// both memories answer in the same cycle
	assign instruction = im_mem[im_address];
	assign dm_out      = dm_mem[dm_address];

	always @(posedge clk) begin
		if (dm_write) begin
			dm_mem[dm_address] <= dm_in;
		end
	end

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	function automatic word_t reg_op(input sub_op_t op, input reg_addr_t rt,
		input reg_addr_t ra, input reg_addr_t rb);
		return {OP_ALU, rt, ra, rb, 6'd0, op};
	endfunction

	function automatic word_t imm_op(input opcode_t op, input reg_addr_t rt,
		input reg_addr_t ra, input logic [15:0] imm);
		return {op, rt, ra, imm};
	endfunction

	function automatic test_t blank_test();
		test_t t;
		t              = '0;
		t.prog         = {PROG_LEN{NOP_INSTR}};
		t.preload_addr = '1;
		return t;
	endfunction

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic expect_flag(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic build_table();
		word_t a;
		word_t b;
		word_t diff;
		word_t chain;
		test_t t;
		// r3 = r1 - r2, r4 = r3 & r2, r5 = r4 | r1, r6 = r5 ^ r3
		a     = 32'd5;
		b     = 32'd7;
		diff  = a - b;
		chain = ((diff & b) | a) ^ diff;

		t = blank_test();
		t.prog[0]  = imm_op(OP_ADDI, 5'd1, 5'd0, 16'd5);
		t.prog[1]  = imm_op(OP_ADDI, 5'd2, 5'd0, 16'd7);
		t.prog[2]  = reg_op(SUB_SUB, 5'd3, 5'd1, 5'd2);
		t.prog[3]  = reg_op(SUB_AND, 5'd4, 5'd3, 5'd2);
		t.prog[4]  = reg_op(SUB_OR, 5'd5, 5'd4, 5'd1);
		t.prog[5]  = reg_op(SUB_XOR, 5'd6, 5'd5, 5'd3);
		t.prog[6]  = imm_op(OP_SWI, 5'd6, 5'd0, 16'h0040);
		t.exp_addr = 12'h040;
		t.exp_data = chain;
		tests[0]   = t;

		// same chain spread out by nops
		t = blank_test();
		t.prog[0]  = imm_op(OP_ADDI, 5'd1, 5'd0, 16'd5);
		t.prog[1]  = imm_op(OP_ADDI, 5'd2, 5'd0, 16'd7);
		t.prog[3]  = reg_op(SUB_SUB, 5'd3, 5'd1, 5'd2);
		t.prog[5]  = reg_op(SUB_AND, 5'd4, 5'd3, 5'd2);
		t.prog[8]  = reg_op(SUB_OR, 5'd5, 5'd4, 5'd1);
		t.prog[10] = reg_op(SUB_XOR, 5'd6, 5'd5, 5'd3);
		t.prog[13] = imm_op(OP_SWI, 5'd6, 5'd0, 16'h0044);
		t.exp_addr = 12'h044;
		t.exp_data = chain;
		tests[1]   = t;

		// load feeds the very next add
		t = blank_test();
		t.prog[0]     = imm_op(OP_ADDI, 5'd1, 5'd0, 16'h0123);
		t.prog[1]     = imm_op(OP_ADDI, 5'd4, 5'd0, 16'h0055);
		t.prog[2]     = imm_op(OP_SWI, 5'd1, 5'd0, 16'h0080);
		t.prog[3]     = imm_op(OP_LWI, 5'd2, 5'd0, 16'h0080);
		t.prog[4]     = reg_op(SUB_ADD, 5'd3, 5'd2, 5'd4);
		t.prog[5]     = imm_op(OP_SWI, 5'd3, 5'd0, 16'h0084);
		t.skip_stores = 2'd1;
		t.exp_addr    = 12'h084;
		t.exp_data    = 32'h0000_0123 + 32'h0000_0055;
		tests[2]      = t;

		t = blank_test();
		t.prog[0]  = imm_op(OP_ADDI, 5'd1, 5'd0, 16'd3);
		t.prog[1]  = imm_op(OP_ADDI, 5'd2, 5'd0, 16'd3);
		t.prog[2]  = imm_op(OP_BEQ, 5'd2, 5'd1, 16'd2);
		t.prog[3]  = imm_op(OP_ADDI, 5'd1, 5'd1, 16'd100);
		t.prog[4]  = reg_op(SUB_ADD, 5'd3, 5'd1, 5'd2);
		t.prog[5]  = imm_op(OP_SWI, 5'd3, 5'd0, 16'h0090);
		t.exp_addr = 12'h090;
		t.exp_data = 32'd3 + 32'd3;
		tests[3]   = t;

		t = blank_test();
		t.prog[0]  = imm_op(OP_ADDI, 5'd1, 5'd0, 16'd3);
		t.prog[1]  = imm_op(OP_ADDI, 5'd2, 5'd0, 16'd4);
		t.prog[2]  = imm_op(OP_BEQ, 5'd2, 5'd1, 16'd2);
		t.prog[3]  = imm_op(OP_ADDI, 5'd1, 5'd1, 16'd100);
		t.prog[4]  = reg_op(SUB_ADD, 5'd3, 5'd1, 5'd2);
		t.prog[5]  = imm_op(OP_SWI, 5'd3, 5'd0, 16'h0094);
		t.exp_addr = 12'h094;
		t.exp_data = (32'd3 + 32'd100) + 32'd4;
		tests[4]   = t;

		// largest positive word comes from data memory
		t = blank_test();
		t.prog[0]      = imm_op(OP_LWI, 5'd1, 5'd0, 16'h00a0);
		t.prog[1]      = imm_op(OP_ADDI, 5'd2, 5'd0, 16'd1);
		t.prog[2]      = reg_op(SUB_ADD, 5'd3, 5'd1, 5'd2);
		t.prog[3]      = imm_op(OP_SWI, 5'd3, 5'd0, 16'h00a4);
		t.preload_addr = 12'h0a0;
		t.preload_data = 32'h7fff_ffff;
		t.exp_addr     = 12'h0a4;
		t.exp_data     = 32'h7fff_ffff + 32'd1;
		t.exp_ovf      = 1'b1;
		tests[5]       = t;
	endtask

	task automatic load_memories(input test_t t);
		for (int a = 0; a < (1 << IM_ADDR_W); a++) begin
			im_mem[a] = NOP_INSTR;
		end
		for (int a = 0; a < PROG_LEN; a++) begin
			im_mem[a] = t.prog[a];
		end
		for (int a = 0; a < (1 << DM_ADDR_W); a++) begin
			dm_mem[a] <= $urandom;
		end
		dm_mem[t.preload_addr] <= t.preload_data;
	endtask

	task automatic run_program(input test_t t);
		int   stores;
		logic ovf_seen;
		logic done;
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		load_memories(t);
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			expect_flag("im_read", im_read, 1'b0);
			expect_flag("dm_read", dm_read, 1'b0);
			expect_flag("dm_write", dm_write, 1'b0);
			expect_flag("alu_overflow", alu_overflow, 1'b0);
			compare_word("im_address", 32'(im_address), '0);
		end
		@(posedge clk);
		#1;
		rst_n    = 1'b1;
		stores   = 0;
		ovf_seen = 1'b0;
		done     = 1'b0;
		while (!done) begin
			@(negedge clk);
			ovf_seen = ovf_seen | alu_overflow;
			if (dm_write) begin
				if (stores == int'(t.skip_stores)) begin
					compare_word("dm_address", 32'(dm_address), 32'(t.exp_addr));
					compare_word("dm_in", dm_in, t.exp_data);
					done = 1'b1;
				end
				stores++;
			end
		end
		expect_flag("alu_overflow", ovf_seen, t.exp_ovf);
	endtask

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout: the program table did not finish within %0d ns", WATCHDOG_NS);
		$display("%0d checks, %0d errors", checks, errors);
		$display("Some tests failed");
		$finish;
	end

	initial begin : main
		checks = 0;
		errors = 0;
		rst_n  = 1'b0;
		void'($urandom(84387));
		build_table();
		load_memories(tests[0]);
		for (int i = 0; i < NUM_TESTS; i++) begin
			run_program(tests[i]);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
source/cpu_pkg.sv
source/fetch_pc.sv
source/decoder.sv
source/regfile.sv
source/operand_forward.sv
source/alu.sv
source/stage_regs.sv
source/pipeline_top.sv
tb/pipeline_props.sv
tb/pipeline_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -Wno-fatal
TOP       = pipeline_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^All tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
